// File: hdl/text_video_pkg.sv
`default_nettype none

package text_video_pkg;

   localparam int WB_ADR_W  = 12;
   localparam int WB_DAT_W  = 8;
   localparam int FONT_ROWS = 8;  // scanlines per character cell
   localparam int PIX_W     = 16; // rgb565
   localparam int PAL_IDX_W = 4;

   localparam logic [WB_ADR_W-1:0] TEXT_BASE = 12'h100;
   localparam logic [WB_ADR_W-1:0] FONT_BASE = 12'h800; // code * 8 + scanline

   typedef enum logic [WB_ADR_W-1:0] {
      REG_CTRL     = 12'h000,  // wr bit 0 starts a frame, rd bit 0 is busy
      REG_FG       = 12'h001,
      REG_BG       = 12'h002,
      REG_PAL_IDX  = 12'h004,
      REG_PAL_DATA = 12'h005   // low byte, then high byte
   } reg_addr_e;

   typedef enum logic [1:0] {
      PAL_IDLE,
      PAL_LO,
      PAL_HI
   } pal_wr_state_e;

   typedef enum logic [2:0] {
      FETCH_IDLE,
      FETCH_CHAR,
      FETCH_FONT,
      FETCH_WRITE,
      FETCH_LINE_END
   } fetch_state_e;

endpackage

`default_nettype wire

// File: hdl/cpu_reg_port.sv
`default_nettype none

module cpu_reg_port (
   input  wire                                  sys_clk,
   input  wire                                  arst_n,
   input  wire                                  wb_cyc,
   input  wire                                  wb_stb,
   input  wire                                  wb_we,
   input  wire  [text_video_pkg::WB_ADR_W-1:0]  wb_adr,
   input  wire  [text_video_pkg::WB_DAT_W-1:0]  wb_dat_w,
   output logic [text_video_pkg::WB_DAT_W-1:0]  wb_dat_r,
   output logic                                 wb_ack,
   input  wire                                  busy,
   output logic                                 frame_start,
   output logic                                 mem_we,
   output logic [text_video_pkg::WB_ADR_W-1:0]  mem_adr,
   output logic [text_video_pkg::WB_DAT_W-1:0]  mem_dat,
   output logic [text_video_pkg::PAL_IDX_W-1:0] fg_idx,
   output logic [text_video_pkg::PAL_IDX_W-1:0] bg_idx,
   output logic                                 pal_we,
   output logic [text_video_pkg::PAL_IDX_W-1:0] pal_idx,
   output logic [text_video_pkg::PIX_W-1:0]     pal_dat
);

   text_video_pkg::reg_addr_e            reg_adr;
   text_video_pkg::pal_wr_state_e        pal_state;
   logic                                 wr_ack;
   logic [text_video_pkg::PAL_IDX_W-1:0] pal_wr_idx;
   logic [text_video_pkg::WB_DAT_W-1:0]  pal_lo;

   assign reg_adr = text_video_pkg::reg_addr_e'(wb_adr);
   assign wr_ack  = wb_ack && wb_we;  // write lands on the ack cycle

   assign mem_we  = wr_ack && (wb_adr >= text_video_pkg::TEXT_BASE);
   assign mem_adr = wb_adr;
   assign mem_dat = wb_dat_w;

   always_comb begin
      wb_dat_r = '0;
      case (reg_adr)
         text_video_pkg::REG_CTRL: wb_dat_r[0] = busy;
         text_video_pkg::REG_FG:   wb_dat_r[text_video_pkg::PAL_IDX_W-1:0] = fg_idx;
         text_video_pkg::REG_BG:   wb_dat_r[text_video_pkg::PAL_IDX_W-1:0] = bg_idx;
         default: ;                // memories read back as zero
      endcase
   end

   always_ff @(posedge sys_clk or negedge arst_n) begin
      if (!arst_n) begin
         wb_ack      <= 1'b0;
         frame_start <= 1'b0;
         fg_idx      <= '0;
         bg_idx      <= '0;
         pal_state   <= text_video_pkg::PAL_IDLE;
         pal_wr_idx  <= '0;
         pal_we      <= 1'b0;
      end else begin
         wb_ack      <= wb_cyc && wb_stb && !wb_ack;
         frame_start <= wr_ack && (reg_adr == text_video_pkg::REG_CTRL) && wb_dat_w[0] && !busy;
         pal_we      <= 1'b0;
         if (wr_ack) begin
            case (reg_adr)
               text_video_pkg::REG_FG: fg_idx <= wb_dat_w[text_video_pkg::PAL_IDX_W-1:0];
               text_video_pkg::REG_BG: bg_idx <= wb_dat_w[text_video_pkg::PAL_IDX_W-1:0];
               text_video_pkg::REG_PAL_IDX: begin
                  pal_wr_idx <= wb_dat_w[text_video_pkg::PAL_IDX_W-1:0];
                  pal_state  <= text_video_pkg::PAL_LO;
               end
               text_video_pkg::REG_PAL_DATA: begin
                  if (pal_state == text_video_pkg::PAL_LO) begin
                     pal_state <= text_video_pkg::PAL_HI;
                  end else if (pal_state == text_video_pkg::PAL_HI) begin
                     pal_we     <= 1'b1;
                     pal_wr_idx <= pal_wr_idx + 1'b1;  // autoincrement
                     pal_state  <= text_video_pkg::PAL_LO;
                  end
               end
               default: ;
            endcase
         end
      end
   end

   always_ff @(posedge sys_clk) begin
      if (wr_ack && reg_adr == text_video_pkg::REG_PAL_DATA) begin
         if (pal_state == text_video_pkg::PAL_LO)
            pal_lo <= wb_dat_w;
         if (pal_state == text_video_pkg::PAL_HI) begin
            pal_idx <= pal_wr_idx;
            pal_dat <= {wb_dat_w, pal_lo};
         end
      end
   end

   ack_needs_stb: assert property (@(posedge sys_clk) disable iff (!arst_n)
      wb_ack |-> wb_stb);

endmodule

`default_nettype wire

// File: hdl/char_fetcher.sv
`default_nettype none

module char_fetcher #(
   parameter int LINE_CHARS = 8,
   parameter int TEXT_ROWS  = 2
) (
   input  wire                                 sys_clk,
   input  wire                                 arst_n,
   input  wire                                 mem_we,
   input  wire  [text_video_pkg::WB_ADR_W-1:0] mem_adr,
   input  wire  [text_video_pkg::WB_DAT_W-1:0] mem_dat,
   input  wire                                 frame_start,
   input  wire                                 pixel_done,
   output logic                                busy,
   input  wire  [1:0]                          bank_full,
   output logic                                wr_en,
   output logic                                wr_bank,
   output logic [$clog2(LINE_CHARS)-1:0]       wr_addr,
   output logic [text_video_pkg::WB_DAT_W-1:0] wr_dat,
   output logic                                wr_commit
);

   localparam int COL_W   = $clog2(LINE_CHARS);
   localparam int ROW_W   = $clog2(TEXT_ROWS + 1);
   localparam int SCAN_W  = $clog2(text_video_pkg::FONT_ROWS);
   localparam int FONT_AW = text_video_pkg::WB_ADR_W - 1;
   localparam int DW      = text_video_pkg::WB_DAT_W;

   logic [DW-1:0]                text_mem [0:255];
   logic [DW-1:0]                font_mem [0:2**FONT_AW-1];
   logic [DW-1:0]                text_q;
   logic [DW-1:0]                font_q;
   logic [7:0]                   text_rd_adr;
   logic [FONT_AW-1:0]           font_rd_adr;
   text_video_pkg::fetch_state_e state;
   logic [COL_W-1:0]             col;
   logic [ROW_W-1:0]             row;
   logic [SCAN_W-1:0]            scan;
   logic                         bank;

   // read addresses follow the counters, data shows up a cycle later
   assign text_rd_adr = 8'(row * LINE_CHARS + col);
   assign font_rd_adr = FONT_AW'(text_q * text_video_pkg::FONT_ROWS + scan);

   always_ff @(posedge sys_clk) begin
      if (mem_we && mem_adr >= text_video_pkg::FONT_BASE)
         font_mem[mem_adr[FONT_AW-1:0]] <= mem_dat;
      else if (mem_we && mem_adr[11:8] == text_video_pkg::TEXT_BASE[11:8])
         text_mem[mem_adr[7:0]] <= mem_dat;
      text_q <= text_mem[text_rd_adr];
      font_q <= font_mem[font_rd_adr];
   end

   assign wr_en     = (state == text_video_pkg::FETCH_WRITE) && !bank_full[bank];
   assign wr_bank   = bank;
   assign wr_addr   = col;
   assign wr_dat    = font_q;
   assign wr_commit = wr_en && (col == COL_W'(LINE_CHARS - 1));

   always_ff @(posedge sys_clk or negedge arst_n) begin
      if (!arst_n) begin
         state <= text_video_pkg::FETCH_IDLE;
         busy  <= 1'b0;
         col   <= '0;
         row   <= '0;
         scan  <= '0;
         bank  <= 1'b0;
      end else begin
         if (pixel_done)
            busy <= 1'b0;  // scanout sent the last pixel
         case (state)
            text_video_pkg::FETCH_IDLE: begin
               if (frame_start) begin
                  busy  <= 1'b1;
                  col   <= '0;
                  row   <= '0;
                  scan  <= '0;
                  state <= text_video_pkg::FETCH_CHAR;
               end
            end
            text_video_pkg::FETCH_CHAR: state <= text_video_pkg::FETCH_FONT;
            text_video_pkg::FETCH_FONT: state <= text_video_pkg::FETCH_WRITE;
            text_video_pkg::FETCH_WRITE: begin
               // stalls here while the scanout still owns the bank
               if (wr_commit) begin
                  col   <= '0;
                  bank  <= !bank;
                  state <= text_video_pkg::FETCH_LINE_END;
               end else if (wr_en) begin
                  col   <= col + 1'b1;
                  state <= text_video_pkg::FETCH_CHAR;
               end
            end
            text_video_pkg::FETCH_LINE_END: begin
               state <= text_video_pkg::FETCH_CHAR;
               if (scan == SCAN_W'(text_video_pkg::FONT_ROWS - 1)) begin
                  scan <= '0;
                  row  <= row + 1'b1;
                  if (row == ROW_W'(TEXT_ROWS - 1))
                     state <= text_video_pkg::FETCH_IDLE;
               end else begin
                  scan <= scan + 1'b1;
               end
            end
            default: state <= text_video_pkg::FETCH_IDLE;
         endcase
      end
   end

   // a start only arrives once the previous frame has drained
   idle_at_frame_start: assert property (@(posedge sys_clk) disable iff (!arst_n)
      frame_start |-> state == text_video_pkg::FETCH_IDLE);

endmodule

`default_nettype wire

// File: hdl/line_buffer.sv
`default_nettype none

module line_buffer #(
   parameter int LINE_CHARS = 8
) (
   input  wire                                 sys_clk,
   input  wire                                 arst_n,
   input  wire                                 wr_en,
   input  wire                                 wr_bank,
   input  wire  [$clog2(LINE_CHARS)-1:0]       wr_addr,
   input  wire  [text_video_pkg::WB_DAT_W-1:0] wr_dat,
   input  wire                                 wr_commit,
   input  wire                                 rd_bank,
   input  wire  [$clog2(LINE_CHARS)-1:0]       rd_addr,
   input  wire                                 rd_release,
   output logic [text_video_pkg::WB_DAT_W-1:0] rd_dat,
   output logic [1:0]                          bank_full
);

   logic [text_video_pkg::WB_DAT_W-1:0] mem [0:2*LINE_CHARS-1];

   always_ff @(posedge sys_clk) begin
      if (wr_en)
         mem[wr_bank * LINE_CHARS + wr_addr] <= wr_dat;
      rd_dat <= mem[rd_bank * LINE_CHARS + rd_addr];  // registered read
   end

   // commit from the fetcher fills a bank, release from the scanout empties it
   always_ff @(posedge sys_clk or negedge arst_n) begin
      if (!arst_n) begin
         bank_full <= 2'b00;
      end else begin
         for (int b = 0; b < 2; b++) begin
            if (wr_commit && wr_bank == 1'(b))
               bank_full[b] <= 1'b1;
            else if (rd_release && rd_bank == 1'(b))
               bank_full[b] <= 1'b0;
         end
      end
   end

   commit_release_apart: assert property (@(posedge sys_clk) disable iff (!arst_n)
      !(wr_commit && rd_release && wr_bank == rd_bank));

endmodule

`default_nettype wire

// File: hdl/pixel_scanout.sv
`default_nettype none

module pixel_scanout #(
   parameter int LINE_CHARS = 8,
   parameter int TEXT_ROWS  = 2
) (
   input  wire                                  sys_clk,
   input  wire                                  arst_n,
   input  wire  [text_video_pkg::PAL_IDX_W-1:0] fg_idx,
   input  wire  [text_video_pkg::PAL_IDX_W-1:0] bg_idx,
   input  wire                                  pal_we,
   input  wire  [text_video_pkg::PAL_IDX_W-1:0] pal_idx,
   input  wire  [text_video_pkg::PIX_W-1:0]     pal_dat,
   input  wire  [1:0]                           bank_full,
   input  wire  [text_video_pkg::WB_DAT_W-1:0]  rd_dat,
   output logic                                 rd_bank,
   output logic [$clog2(LINE_CHARS)-1:0]        rd_addr,
   output logic                                 rd_release,
   output logic                                 pixel_done,
   output logic                                 pix_valid,
   output logic [text_video_pkg::PIX_W-1:0]     pix_data,
   output logic                                 pix_line_last,
   output logic                                 pix_frame_last,
   input  wire                                  pix_ready
);

   localparam int ADR_W  = $clog2(LINE_CHARS);
   localparam int LINES  = TEXT_ROWS * text_video_pkg::FONT_ROWS;
   localparam int LINE_W = $clog2(LINES);

   logic [text_video_pkg::PIX_W-1:0]    pal_mem [0:2**text_video_pkg::PAL_IDX_W-1];
   logic [text_video_pkg::WB_DAT_W-1:0] shift;
   logic [3:0]                          sh_cnt;      // bits left in shift
   logic                                sh_line_end; // shift holds the line's last byte
   logic                                rd_pend;
   logic                                rd_last;
   logic                                rd_go;
   logic                                emit;
   logic                                bit_line_last;
   logic [LINE_W-1:0]                   line_cnt;

   assign rd_go         = (sh_cnt == 4'd0) && !rd_pend && bank_full[rd_bank];
   assign emit          = (sh_cnt != 4'd0) && (!pix_valid || pix_ready);
   assign bit_line_last = sh_line_end && (sh_cnt == 4'd1);
   assign rd_release    = rd_pend && rd_last;
   assign pixel_done    = pix_valid && pix_ready && pix_frame_last;

   always_ff @(posedge sys_clk) begin
      if (pal_we)
         pal_mem[pal_idx] <= pal_dat;
      if (rd_pend) begin
         shift       <= rd_dat;
         sh_line_end <= rd_last;
      end else if (emit) begin
         shift <= {shift[6:0], 1'b0};  // msb first
      end
      if (emit) begin
         pix_data       <= pal_mem[shift[7] ? fg_idx : bg_idx];
         pix_line_last  <= bit_line_last;
         pix_frame_last <= bit_line_last && (line_cnt == LINE_W'(LINES - 1));
      end
   end

   always_ff @(posedge sys_clk or negedge arst_n) begin
      if (!arst_n) begin
         rd_bank   <= 1'b0;
         rd_addr   <= '0;
         rd_pend   <= 1'b0;
         rd_last   <= 1'b0;
         sh_cnt    <= '0;
         line_cnt  <= '0;
         pix_valid <= 1'b0;
      end else begin
         rd_pend <= rd_go;
         if (rd_go) begin
            rd_last <= (rd_addr == ADR_W'(LINE_CHARS - 1));
            rd_addr <= (rd_addr == ADR_W'(LINE_CHARS - 1)) ? '0 : rd_addr + 1'b1;
         end
         if (rd_pend) begin
            sh_cnt <= 4'd8;
            if (rd_last)
               rd_bank <= !rd_bank;  // bank released this cycle
         end else if (emit) begin
            sh_cnt <= sh_cnt - 1'b1;
         end
         if (emit) begin
            pix_valid <= 1'b1;
            if (bit_line_last)
               line_cnt <= (line_cnt == LINE_W'(LINES - 1)) ? '0 : line_cnt + 1'b1;
         end else if (pix_ready) begin
            pix_valid <= 1'b0;
         end
      end
   end

   stall_holds: assert property (@(posedge sys_clk) disable iff (!arst_n)
      pix_valid && !pix_ready |=> pix_valid && $stable(pix_data)
         && $stable(pix_line_last) && $stable(pix_frame_last));

endmodule

`default_nettype wire

// File: hdl/text_video_top.sv
`default_nettype none

module text_video_top #(
   parameter int LINE_CHARS = 8,
   parameter int TEXT_ROWS  = 2   // LINE_CHARS * TEXT_ROWS must stay within 256
) (
   input  wire                                 sys_clk,
   input  wire                                 arst_n,
   input  wire                                 wb_cyc,
   input  wire                                 wb_stb,
   input  wire                                 wb_we,
   input  wire  [text_video_pkg::WB_ADR_W-1:0] wb_adr,
   input  wire  [text_video_pkg::WB_DAT_W-1:0] wb_dat_w,
   output logic [text_video_pkg::WB_DAT_W-1:0] wb_dat_r,
   output logic                                wb_ack,
   output logic                                pix_valid,
   output logic [text_video_pkg::PIX_W-1:0]    pix_data,
   output logic                                pix_line_last,
   output logic                                pix_frame_last,
   input  wire                                 pix_ready
);

   localparam int COL_W = $clog2(LINE_CHARS);

   wire                                 busy;
   wire                                 frame_start;
   wire                                 pixel_done;
   wire                                 mem_we;
   wire [text_video_pkg::WB_ADR_W-1:0]  mem_adr;
   wire [text_video_pkg::WB_DAT_W-1:0]  mem_dat;
   wire [text_video_pkg::PAL_IDX_W-1:0] fg_idx;
   wire [text_video_pkg::PAL_IDX_W-1:0] bg_idx;
   wire                                 pal_we;
   wire [text_video_pkg::PAL_IDX_W-1:0] pal_idx;
   wire [text_video_pkg::PIX_W-1:0]     pal_dat;
   wire                                 wr_en;
   wire                                 wr_bank;
   wire [COL_W-1:0]                     wr_addr;
   wire [text_video_pkg::WB_DAT_W-1:0]  wr_dat;
   wire                                 wr_commit;
   wire [1:0]                           bank_full;
   wire                                 rd_bank;
   wire [COL_W-1:0]                     rd_addr;
   wire                                 rd_release;
   wire [text_video_pkg::WB_DAT_W-1:0]  rd_dat;

   cpu_reg_port cpu_reg_port_inst (
      .sys_clk, .arst_n, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r,
      .wb_ack, .busy, .frame_start, .mem_we, .mem_adr, .mem_dat, .fg_idx, .bg_idx,
      .pal_we, .pal_idx, .pal_dat
   );

   char_fetcher #(.LINE_CHARS(LINE_CHARS), .TEXT_ROWS(TEXT_ROWS)) char_fetcher_inst (
      .sys_clk, .arst_n, .mem_we, .mem_adr, .mem_dat, .frame_start, .pixel_done,
      .busy, .bank_full, .wr_en, .wr_bank, .wr_addr, .wr_dat, .wr_commit
   );

   line_buffer #(.LINE_CHARS(LINE_CHARS)) line_buffer_inst (
      .sys_clk, .arst_n, .wr_en, .wr_bank, .wr_addr, .wr_dat, .wr_commit,
      .rd_bank, .rd_addr, .rd_release, .rd_dat, .bank_full
   );

   pixel_scanout #(.LINE_CHARS(LINE_CHARS), .TEXT_ROWS(TEXT_ROWS)) pixel_scanout_inst (
      .sys_clk, .arst_n, .fg_idx, .bg_idx, .pal_we, .pal_idx, .pal_dat, .bank_full,
      .rd_dat, .rd_bank, .rd_addr, .rd_release, .pixel_done, .pix_valid, .pix_data,
      .pix_line_last, .pix_frame_last, .pix_ready
   );

endmodule

`default_nettype wire

// File: dv/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen #(
   parameter int PERIOD       = 8,
   parameter int RESET_CYCLES = 5
) (
   output logic sys_clk,
   output logic arst_n
);

   initial begin
      sys_clk = 1'b0;
      forever #(PERIOD / 2) sys_clk = ~sys_clk;
   end

   initial begin
      arst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge sys_clk);
      @(negedge sys_clk);
      arst_n = 1'b1;  // released away from the active edge
   end

endmodule

`default_nettype wire

// File: dv/text_video_tb.sv
`default_nettype none

module text_video_tb;

   localparam int LINE_CHARS    = 8;
   localparam int TEXT_ROWS     = 2;
   localparam int LINE_PIX      = LINE_CHARS * 8;
   localparam int PIX_PER_FRAME = LINE_PIX * TEXT_ROWS * text_video_pkg::FONT_ROWS;
   localparam int NUM_TESTS     = 5;
   localparam int FONT_CODES    = 16;  // text only uses codes 0..15
   localparam int WATCHDOG_CYCLES = NUM_TESTS * PIX_PER_FRAME * 6 + 2000;
   localparam logic [31:0] SEED = 32'h5271_eb69;
   localparam logic [1:0] FONT_ONES  = 2'd0;
   localparam logic [1:0] FONT_ZEROS = 2'd1;
   localparam logic [1:0] FONT_MIXED = 2'd2;

   typedef struct packed {
      logic [1:0]  font_kind;
      logic [7:0]  text_seed;
      logic [15:0] pal_seed;
      logic [3:0]  fg;
      logic [3:0]  bg;
      logic        stall;
   } test_entry_t;

   logic        sys_clk;
   logic        arst_n;
   logic        wb_cyc;
   logic        wb_stb;
   logic        wb_we;
   logic [11:0] wb_adr;
   logic [7:0]  wb_dat_w;
   logic [7:0]  wb_dat_r;
   logic        wb_ack;
   logic        pix_valid;
   logic [15:0] pix_data;
   logic        pix_line_last;
   logic        pix_frame_last;
   logic        pix_ready;

   test_entry_t tests [NUM_TESTS];
   logic [7:0]  text_ref [0:LINE_CHARS*TEXT_ROWS-1];  // reference model contents
   logic [7:0]  font_ref [0:2047];
   logic [15:0] pal_ref  [0:15];
   logic [3:0]  cur_fg;
   logic [3:0]  cur_bg;
   int          errors;
   int          checks;

   tb_clock_gen clock_gen_inst (.sys_clk, .arst_n);

   text_video_top text_video_top_inst (
      .sys_clk, .arst_n, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
      .pix_valid, .pix_data, .pix_line_last, .pix_frame_last, .pix_ready
   );

   // called on a falling edge, returns on a falling edge
   task automatic bus_cycle(input logic we, input logic [11:0] adr, input logic [7:0] dat,
                            output logic [7:0] rdat);
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = we;
      wb_adr   = adr;
      wb_dat_w = dat;
      @(negedge sys_clk);
      while (!wb_ack) @(negedge sys_clk);
      rdat = wb_dat_r;
      @(negedge sys_clk);  // hold through the ack edge
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
   endtask

   task automatic write_byte(input logic [11:0] adr, input logic [7:0] dat);
      logic [7:0] unused;
      bus_cycle(1'b1, adr, dat, unused);
   endtask

   task automatic expect_register(input logic [11:0] adr, input logic [7:0] exp, string what);
      logic [7:0] got;
      bus_cycle(1'b0, adr, 8'h00, got);
      checks++;
      assert (got == exp) else begin
         $display("MISMATCH at %0t: %s read 0x%02h, expected 0x%02h", $time, what, got, exp);
         errors++;
      end
   endtask

   function automatic logic [7:0] font_byte(input logic [1:0] kind, input int code,
                                            input int scan);
      case (kind)
         FONT_ONES:  return 8'hff;
         FONT_ZEROS: return 8'h00;
         default:    return 8'((code * 29) ^ (scan * 53) ^ (code << 4) ^ 8'h5a);
      endcase
   endfunction

   task automatic load_memories(input test_entry_t e);
      write_byte(12'(text_video_pkg::REG_PAL_IDX), 8'h00);
      for (int i = 0; i < 16; i++) begin
         pal_ref[i] = 16'(e.pal_seed * (i + 1)) ^ 16'(i * 16'h0841);
         write_byte(12'(text_video_pkg::REG_PAL_DATA), pal_ref[i][7:0]);
         write_byte(12'(text_video_pkg::REG_PAL_DATA), pal_ref[i][15:8]);
      end
      for (int c = 0; c < FONT_CODES; c++) begin
         for (int s = 0; s < text_video_pkg::FONT_ROWS; s++) begin
            font_ref[c*8 + s] = font_byte(e.font_kind, c, s);
            write_byte(12'(text_video_pkg::FONT_BASE + c*8 + s), font_ref[c*8 + s]);
         end
      end
      for (int i = 0; i < LINE_CHARS * TEXT_ROWS; i++) begin
         text_ref[i] = 8'((e.text_seed * 13 + i * 7 + (i >> 3)) & 8'h0f);
         write_byte(12'(text_video_pkg::TEXT_BASE + i), text_ref[i]);
      end
      cur_fg = e.fg;
      cur_bg = e.bg;
      write_byte(12'(text_video_pkg::REG_FG), {4'h0, e.fg});
      write_byte(12'(text_video_pkg::REG_BG), {4'h0, e.bg});
      expect_register(12'(text_video_pkg::REG_FG), {4'h0, e.fg}, "REG_FG");
      expect_register(12'(text_video_pkg::REG_BG), {4'h0, e.bg}, "REG_BG");
   endtask

   function automatic logic [15:0] expected_pixel(input int n);
      int         line;
      int         x;
      logic [7:0] code;
      logic [7:0] bits;
      line = n / LINE_PIX;
      x    = n % LINE_PIX;
      code = text_ref[(line / text_video_pkg::FONT_ROWS) * LINE_CHARS + x / 8];
      bits = font_ref[code * 8 + line % text_video_pkg::FONT_ROWS];
      return bits[7 - x % 8] ? pal_ref[cur_fg] : pal_ref[cur_bg];
   endfunction

   task automatic check_pixel(input int n);
      logic [15:0] exp_pix;
      logic        exp_line;
      logic        exp_frame;
      exp_pix   = expected_pixel(n);
      exp_line  = (n % LINE_PIX) == LINE_PIX - 1;
      exp_frame = n == PIX_PER_FRAME - 1;
      checks++;
      assert (pix_data == exp_pix && pix_line_last == exp_line && pix_frame_last == exp_frame)
      else begin
         $display("MISMATCH at %0t: pixel %0d got %04h/%b/%b, expected %04h/%b/%b", $time, n,
                  pix_data, pix_line_last, pix_frame_last, exp_pix, exp_line, exp_frame);
         errors++;
      end
   endtask

   // ready is chosen on the falling edge, so a transfer is known before the rising edge
   task automatic collect_frame(input logic stall);
      int          n;
      logic        ready;
      logic        held;
      logic [15:0] held_data;
      logic [1:0]  held_flags;
      n    = 0;
      held = 1'b0;
      while (n < PIX_PER_FRAME) begin
         @(negedge sys_clk);
         if (held) begin
            checks++;
            assert (pix_valid && pix_data == held_data
                    && {pix_line_last, pix_frame_last} == held_flags)
            else begin
               $display("MISMATCH at %0t: stream changed while stalled at pixel %0d", $time, n);
               errors++;
            end
         end
         ready      = stall ? 1'($urandom % 2) : 1'b1;
         pix_ready  = ready;
         held       = pix_valid && !ready;
         held_data  = pix_data;
         held_flags = {pix_line_last, pix_frame_last};
         if (pix_valid && ready) begin
            check_pixel(n);
            n++;
         end
      end
      pix_ready = 1'b1;
   endtask

   task automatic run_test(input int t);
      int errors_before;
      errors_before = errors;
      load_memories(tests[t]);
      fork
         collect_frame(tests[t].stall);
         begin
            write_byte(12'(text_video_pkg::REG_CTRL), 8'h01);
            expect_register(12'(text_video_pkg::REG_CTRL), 8'h01, "busy during frame");
         end
      join
      expect_register(12'(text_video_pkg::REG_CTRL), 8'h00, "busy after frame");
      $display("test %0d: font %0d fg %0d bg %0d stall %b, %0d errors", t, tests[t].font_kind,
               tests[t].fg, tests[t].bg, tests[t].stall, errors - errors_before);
   endtask

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge sys_clk);
      $display("timeout: the run did not end within %0d cycles", WATCHDOG_CYCLES);
      $display("Finished with errors");
      $finish;
   end

   initial begin
      wb_cyc    = 1'b0;
      wb_stb    = 1'b0;
      wb_we     = 1'b0;
      wb_adr    = '0;
      wb_dat_w  = '0;
      pix_ready = 1'b1;  // keeps a finished frame from leaving a stale pixel behind
      errors    = 0;
      checks    = 0;
      void'($urandom(SEED));
      tests[0] = '{FONT_ONES,  8'd1, 16'h1234, 4'd3, 4'd12, 1'b0};
      tests[1] = '{FONT_ZEROS, 8'd2, 16'h1234, 4'd3, 4'd12, 1'b0};
      tests[2] = '{FONT_MIXED, 8'd5, 16'h0bad, 4'd1, 4'd14, 1'b0};
      tests[3] = '{FONT_MIXED, 8'd5, 16'h0bad, 4'd1, 4'd14, 1'b1};  // same frame, stalled
      tests[4] = '{FONT_MIXED, 8'd9, 16'h0bad, 4'd7, 4'd0,  1'b1};
      wait (arst_n === 1'b1);
      @(negedge sys_clk);
      for (int t = 0; t < NUM_TESTS; t++)
         run_test(t);
      $display("%0d tests, %0d checks, %0d errors", NUM_TESTS, checks, errors);
      if (errors == 0)
         $display("Finished with no errors");
      else
         $display("Finished with errors");
      $finish;
   end

endmodule

`default_nettype wire

// File: text_video_top.f
hdl/text_video_pkg.sv
hdl/cpu_reg_port.sv
hdl/char_fetcher.sv
hdl/line_buffer.sv
hdl/pixel_scanout.sv
hdl/text_video_top.sv
dv/tb_clock_gen.sv
dv/text_video_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= text_video_tb
FILELIST  ?= text_video_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := Finished with errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
